/* ooo_issue.f */
source/ooo_cfg_pkg.sv
source/ooo_uop_pkg.sv
source/disp_if.sv
source/issue_if.sv
source/dispatch_stage.sv
source/issue_queue.sv
source/alu_stage.sv
source/ooo_issue_top.sv
tb/tb_ooo_issue.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f ooo_issue.f --top-module tb_ooo_issue -Mdir obj_dir -o tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

/* source/alu_stage.sv */
// single-cycle ALU per issue lane, registers results onto the writeback bus
`timescale 1ns/1ps
`default_nettype none

module alu_stage
    import ooo_cfg_pkg::*, ooo_uop_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    issue_if.dst issue_i,
    output logic [WB_WIDTH-1:0] wb_valid_o,
    output rob_idx_t [WB_WIDTH-1:0] wb_tag_o,
    output xlen_t [WB_WIDTH-1:0] wb_data_o
);

    xlen_t [ISSUE_WIDTH-1:0] result;

    // ==================================================================
    // execute
    // ==================================================================

    always_comb begin : execute
        xlen_t a;
        xlen_t b;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            a = issue_i.rs1_data[k];
            b = issue_i.rs2_data[k];
            case (issue_i.op[k])
                ADD: result[k] = a + b;
                SUB: result[k] = a - b;
                AND: result[k] = a & b;
                OR:  result[k] = a | b;
                XOR: result[k] = a ^ b;
                // shift amount from the low five bits only
                SLL: result[k] = a << b[4:0];
                SRL: result[k] = a >> b[4:0];
                SLT: result[k] = xlen_t'($signed(a) < $signed(b));
                default: result[k] = '0;
            endcase
        end
    end

    // ==================================================================
    // writeback register
    // ==================================================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_valid_o <= '0;
        end else if (flush_i) begin
            wb_valid_o <= '0;
        end else begin
            wb_valid_o <= issue_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_tag_o <= issue_i.rob_idx;
        wb_data_o <= result;
    end

    // a tag lives in one queue slot only, so lanes never share it
    for (genvar i = 0; i < WB_WIDTH; i++) begin : g_wb_pair
        for (genvar j = i + 1; j < WB_WIDTH; j++) begin : g_other
            a_wb_tag_unique: assert property (@(posedge clk_i) disable iff (!rst_ni)
                !(wb_valid_o[i] && wb_valid_o[j] && (wb_tag_o[i] == wb_tag_o[j])))
                else $error("two writeback lanes carry the same tag");
        end
    end

endmodule

`default_nettype wire

/* source/disp_if.sv */
// registered dispatch lanes, driven by the dispatch stage and read by the issue queue
`timescale 1ns/1ps
`default_nettype none

interface disp_if
    import ooo_cfg_pkg::*, ooo_uop_pkg::*;
();

    // one bit or word per dispatch lane
    logic [DISP_WIDTH-1:0] valid;
    alu_op_e [DISP_WIDTH-1:0] op;
    rob_idx_t [DISP_WIDTH-1:0] rob_idx;

    // first source, tag only meaningful while not ready
    logic [DISP_WIDTH-1:0] rs1_ready;
    rob_idx_t [DISP_WIDTH-1:0] rs1_tag;
    xlen_t [DISP_WIDTH-1:0] rs1_data;

    // second source
    logic [DISP_WIDTH-1:0] rs2_ready;
    rob_idx_t [DISP_WIDTH-1:0] rs2_tag;
    xlen_t [DISP_WIDTH-1:0] rs2_data;

    modport src (output valid, op, rob_idx, rs1_ready, rs1_tag, rs1_data,
                 rs2_ready, rs2_tag, rs2_data);
    modport dst (input valid, op, rob_idx, rs1_ready, rs1_tag, rs1_data,
                 rs2_ready, rs2_tag, rs2_data);

endinterface

`default_nettype wire

/* source/dispatch_stage.sv */
// input register of the dispatch lanes, forwards results broadcast in the strobe cycle
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage
    import ooo_cfg_pkg::*, ooo_uop_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    // full flag of the queue, sender has to honor it
    input  logic full_i,
    input  logic [DISP_WIDTH-1:0] disp_valid_i,
    input  alu_op_e [DISP_WIDTH-1:0] disp_op_i,
    input  rob_idx_t [DISP_WIDTH-1:0] disp_rob_idx_i,
    input  logic [DISP_WIDTH-1:0] disp_rs1_ready_i,
    input  rob_idx_t [DISP_WIDTH-1:0] disp_rs1_tag_i,
    input  xlen_t [DISP_WIDTH-1:0] disp_rs1_data_i,
    input  logic [DISP_WIDTH-1:0] disp_rs2_ready_i,
    input  rob_idx_t [DISP_WIDTH-1:0] disp_rs2_tag_i,
    input  xlen_t [DISP_WIDTH-1:0] disp_rs2_data_i,
    // writeback bus, snooped for forwarding
    input  logic [WB_WIDTH-1:0] wb_valid_i,
    input  rob_idx_t [WB_WIDTH-1:0] wb_tag_i,
    input  xlen_t [WB_WIDTH-1:0] wb_data_i,
    disp_if.src disp_o
);

    // any writeback lane carrying this tag
    function automatic logic wb_hit(input rob_idx_t tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < WB_WIDTH; w++) begin
            hit = hit | (wb_valid_i[w] && (wb_tag_i[w] == tag));
        end
        return hit;
    endfunction

    // data of the matching lane, zero when none matches
    function automatic xlen_t wb_value(input rob_idx_t tag);
        xlen_t val;
        val = '0;
        for (int w = 0; w < WB_WIDTH; w++) begin
            if (wb_valid_i[w] && (wb_tag_i[w] == tag)) begin
                val = wb_data_i[w];
            end
        end
        return val;
    endfunction

    // lane valids, flush drops whatever arrives with it
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            disp_o.valid <= '0;
        end else if (flush_i) begin
            disp_o.valid <= '0;
        end else begin
            disp_o.valid <= disp_valid_i;
        end
    end

    // payload
    // a pending source whose producer writes back now is caught here,
    // the queue would otherwise miss that broadcast
    always_ff @(posedge clk_i) begin
        for (int l = 0; l < DISP_WIDTH; l++) begin
            disp_o.op[l] <= disp_op_i[l];
            disp_o.rob_idx[l] <= disp_rob_idx_i[l];
            disp_o.rs1_tag[l] <= disp_rs1_tag_i[l];
            disp_o.rs1_ready[l] <= disp_rs1_ready_i[l] || wb_hit(disp_rs1_tag_i[l]);
            disp_o.rs1_data[l] <= disp_rs1_ready_i[l] ? disp_rs1_data_i[l]
                                                      : wb_value(disp_rs1_tag_i[l]);
            disp_o.rs2_tag[l] <= disp_rs2_tag_i[l];
            disp_o.rs2_ready[l] <= disp_rs2_ready_i[l] || wb_hit(disp_rs2_tag_i[l]);
            disp_o.rs2_data[l] <= disp_rs2_ready_i[l] ? disp_rs2_data_i[l]
                                                      : wb_value(disp_rs2_tag_i[l]);
        end
    end

    // the queue cannot refuse a lane, so a strobe under full would be lost
    a_no_disp_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        full_i |-> (disp_valid_i == '0))
        else $error("dispatch strobe while full_o is high");

endmodule

`default_nettype wire

/* source/issue_if.sv */
// issued micro-ops with captured operands, from the issue queue to the ALU
`timescale 1ns/1ps
`default_nettype none

interface issue_if
    import ooo_cfg_pkg::*, ooo_uop_pkg::*;
();

    // single-cycle strobe per lane, ALU never stalls
    logic [ISSUE_WIDTH-1:0] valid;
    alu_op_e [ISSUE_WIDTH-1:0] op;
    // tag of the result this lane produces
    rob_idx_t [ISSUE_WIDTH-1:0] rob_idx;
    // both operands already resolved
    xlen_t [ISSUE_WIDTH-1:0] rs1_data;
    xlen_t [ISSUE_WIDTH-1:0] rs2_data;

    modport src (output valid, op, rob_idx, rs1_data, rs2_data);
    modport dst (input valid, op, rob_idx, rs1_data, rs2_data);

endinterface

`default_nettype wire

/* source/issue_queue.sv */
// tag-matching issue queue: allocation, wakeup, lowest-slot-first select and occupancy
`timescale 1ns/1ps
`default_nettype none

module issue_queue
    import ooo_cfg_pkg::*, ooo_uop_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    disp_if.dst disp_i,
    input  logic [WB_WIDTH-1:0] wb_valid_i,
    input  rob_idx_t [WB_WIDTH-1:0] wb_tag_i,
    input  xlen_t [WB_WIDTH-1:0] wb_data_i,
    issue_if.src issue_o,
    output logic full_o
);

    // ==================================================================
    // entry storage
    // ==================================================================

    logic [IQ_DEPTH-1:0] valid_q;
    alu_op_e op_q [IQ_DEPTH];
    rob_idx_t rob_q [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] s1_rdy_q;
    logic [IQ_DEPTH-1:0] s2_rdy_q;
    rob_idx_t s1_tag_q [IQ_DEPTH];
    rob_idx_t s2_tag_q [IQ_DEPTH];
    xlen_t s1_data_q [IQ_DEPTH];
    xlen_t s2_data_q [IQ_DEPTH];
    iq_cnt_t count_q;

    // one-hot slot per dispatch lane
    logic [DISP_WIDTH-1:0][IQ_DEPTH-1:0] alloc_oh;
    logic [IQ_DEPTH-1:0] alloc_mask;
    logic [IQ_DEPTH-1:0] grant_mask;

    function automatic logic wb_hit(input rob_idx_t tag);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < WB_WIDTH; w++) begin
            hit = hit | (wb_valid_i[w] && (wb_tag_i[w] == tag));
        end
        return hit;
    endfunction

    function automatic xlen_t wb_value(input rob_idx_t tag);
        xlen_t val;
        val = '0;
        for (int w = 0; w < WB_WIDTH; w++) begin
            if (wb_valid_i[w] && (wb_tag_i[w] == tag)) begin
                val = wb_data_i[w];
            end
        end
        return val;
    endfunction

    // ==================================================================
    // allocation, lowest free slots in lane order
    // ==================================================================

    always_comb begin : alloc_pick
        logic [IQ_DEPTH-1:0] busy;
        busy = valid_q;
        for (int l = 0; l < DISP_WIDTH; l++) begin
            // lowest zero bit of busy, empty when all slots taken
            alloc_oh[l] = disp_i.valid[l] ? (~busy & (busy + 1'b1)) : '0;
            busy = busy | alloc_oh[l];
        end
        alloc_mask = busy & ~valid_q;
    end

    // ==================================================================
    // select, up to ISSUE_WIDTH ready entries, lowest slot first
    // ==================================================================

    always_comb begin : select
        logic [IQ_DEPTH-1:0] cand;
        logic [IQ_DEPTH-1:0] pick;
        cand = valid_q & s1_rdy_q & s2_rdy_q;
        grant_mask = '0;
        for (int k = 0; k < ISSUE_WIDTH; k++) begin
            pick = cand & (~cand + 1'b1);
            issue_o.valid[k] = |pick;
            issue_o.op[k] = ADD;
            issue_o.rob_idx[k] = '0;
            issue_o.rs1_data[k] = '0;
            issue_o.rs2_data[k] = '0;
            // one-hot mux of the picked entry
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (pick[i]) begin
                    issue_o.op[k] = op_q[i];
                    issue_o.rob_idx[k] = rob_q[i];
                    issue_o.rs1_data[k] = s1_data_q[i];
                    issue_o.rs2_data[k] = s2_data_q[i];
                end
            end
            cand = cand & ~pick;
            grant_mask = grant_mask | pick;
        end
    end

    // ==================================================================
    // state update
    // ==================================================================

    // issued slots free at the end of the issue cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
            count_q <= '0;
        end else begin
            valid_q <= (valid_q & ~grant_mask) | alloc_mask;
            count_q <= count_q + iq_cnt_t'($countones(alloc_mask))
                               - iq_cnt_t'($countones(grant_mask));
        end
    end

    // wakeup of waiting sources, then the writes of new lanes
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!s1_rdy_q[i] && wb_hit(s1_tag_q[i])) begin
                s1_rdy_q[i] <= 1'b1;
                s1_data_q[i] <= wb_value(s1_tag_q[i]);
            end
            if (!s2_rdy_q[i] && wb_hit(s2_tag_q[i])) begin
                s2_rdy_q[i] <= 1'b1;
                s2_data_q[i] <= wb_value(s2_tag_q[i]);
            end
            for (int l = 0; l < DISP_WIDTH; l++) begin
                if (alloc_oh[l][i]) begin
                    op_q[i] <= disp_i.op[l];
                    rob_q[i] <= disp_i.rob_idx[l];
                    // a broadcast during the write cycle is captured too
                    s1_tag_q[i] <= disp_i.rs1_tag[l];
                    s1_rdy_q[i] <= disp_i.rs1_ready[l] || wb_hit(disp_i.rs1_tag[l]);
                    s1_data_q[i] <= disp_i.rs1_ready[l] ? disp_i.rs1_data[l]
                                                        : wb_value(disp_i.rs1_tag[l]);
                    s2_tag_q[i] <= disp_i.rs2_tag[l];
                    s2_rdy_q[i] <= disp_i.rs2_ready[l] || wb_hit(disp_i.rs2_tag[l]);
                    s2_data_q[i] <= disp_i.rs2_ready[l] ? disp_i.rs2_data[l]
                                                        : wb_value(disp_i.rs2_tag[l]);
                end
            end
        end
    end

    // lanes still in the dispatch register already own a slot
    assign full_o = (int'(count_q) + $countones(disp_i.valid)) > (IQ_DEPTH - DISP_WIDTH);

    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= iq_cnt_t'(IQ_DEPTH))
        else $error("queue count above depth");

    // holds only while the sender respects full_o
    a_lane_has_slot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $countones(alloc_mask) == $countones(disp_i.valid))
        else $error("dispatch lane found no free slot");

endmodule

`default_nettype wire

/* source/ooo_cfg_pkg.sv */
// sizes and word types of the issue backend, imported by every design unit
`default_nettype none

package ooo_cfg_pkg;

    // ==================================================================
    // sizes
    // ==================================================================

    // operand and result width
    localparam int XLEN = 32;
    // rob tag width, 64 tags in flight
    localparam int ROB_IDX_W = 6;
    // issue queue slots
    localparam int IQ_DEPTH = 8;

    // lanes per stage
    localparam int DISP_WIDTH = 2;
    localparam int ISSUE_WIDTH = 2;
    // one writeback lane per issue lane
    localparam int WB_WIDTH = ISSUE_WIDTH;

    // ==================================================================
    // word types
    // ==================================================================

    // one operand or result
    typedef logic [XLEN-1:0] xlen_t;
    // producer tag, also the name of a pending operand
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    // occupancy, must reach IQ_DEPTH itself
    typedef logic [$clog2(IQ_DEPTH+1)-1:0] iq_cnt_t;

endpackage

`default_nettype wire

/* source/ooo_issue_top.sv */
// top level of the issue backend, dispatch register to issue queue to ALU
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_top
    import ooo_cfg_pkg::*, ooo_uop_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic flush_i,
    // dispatch lanes, strobe only while full_o is low
    input  logic [DISP_WIDTH-1:0] disp_valid_i,
    input  alu_op_e [DISP_WIDTH-1:0] disp_op_i,
    input  rob_idx_t [DISP_WIDTH-1:0] disp_rob_idx_i,
    input  logic [DISP_WIDTH-1:0] disp_rs1_ready_i,
    input  rob_idx_t [DISP_WIDTH-1:0] disp_rs1_tag_i,
    input  xlen_t [DISP_WIDTH-1:0] disp_rs1_data_i,
    input  logic [DISP_WIDTH-1:0] disp_rs2_ready_i,
    input  rob_idx_t [DISP_WIDTH-1:0] disp_rs2_tag_i,
    input  xlen_t [DISP_WIDTH-1:0] disp_rs2_data_i,
    output logic full_o,
    // writeback bus, also fed back to dispatch and wakeup
    output logic [WB_WIDTH-1:0] wb_valid_o,
    output rob_idx_t [WB_WIDTH-1:0] wb_tag_o,
    output xlen_t [WB_WIDTH-1:0] wb_data_o
);

    disp_if u_disp_if ();
    issue_if u_issue_if ();

    dispatch_stage u_dispatch (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .full_i           (full_o),
        .disp_valid_i     (disp_valid_i),
        .disp_op_i        (disp_op_i),
        .disp_rob_idx_i   (disp_rob_idx_i),
        .disp_rs1_ready_i (disp_rs1_ready_i),
        .disp_rs1_tag_i   (disp_rs1_tag_i),
        .disp_rs1_data_i  (disp_rs1_data_i),
        .disp_rs2_ready_i (disp_rs2_ready_i),
        .disp_rs2_tag_i   (disp_rs2_tag_i),
        .disp_rs2_data_i  (disp_rs2_data_i),
        .wb_valid_i       (wb_valid_o),
        .wb_tag_i         (wb_tag_o),
        .wb_data_i        (wb_data_o),
        .disp_o           (u_disp_if.src)
    );

    issue_queue u_iq (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .disp_i     (u_disp_if.dst),
        .wb_valid_i (wb_valid_o),
        .wb_tag_i   (wb_tag_o),
        .wb_data_i  (wb_data_o),
        .issue_o    (u_issue_if.src),
        .full_o     (full_o)
    );

    alu_stage u_alu (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .issue_i    (u_issue_if.dst),
        .wb_valid_o (wb_valid_o),
        .wb_tag_o   (wb_tag_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

`default_nettype wire

/* source/ooo_uop_pkg.sv */
// micro-op encodings shared by the ALU and the testbench reference model
`default_nettype none

package ooo_uop_pkg;

    // alu operations
    // shifts take rs2[4:0] as the amount
    // slt is a signed compare, result is 0 or 1
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

/* tb/tb_ooo_issue.sv */
// testbench of the issue backend, checks every writeback against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_issue
    import ooo_cfg_pkg::*, ooo_uop_pkg::*;
();

    // ==================================================================
    // timing, tag map and run length
    // ==================================================================

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 10;
    localparam int TAGS = 1 << ROB_IDX_W;
    // tag ranges per test, never reused in one run
    localparam int CHAIN_BASE = 8;
    localparam int FWD_BASE = 13;
    localparam int FULL_BASE = 16;
    localparam int RAND_BASE = 24;
    localparam int RAND_OPS = 36;
    // waited on by the full test, produced only once after its flush
    localparam rob_idx_t NEVER_TAG = rob_idx_t'(TAGS - 1);
    // issued in the cycle of the second flush, so it has to vanish
    localparam rob_idx_t DROP_TAG = rob_idx_t'(TAGS - 2);
    // rough length of each test in cycles
    localparam int RUN_CYCLES = RESET_CYCLES + 30 + 30 + 20 + 30 + 4 * RAND_OPS;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + 200;

    logic clk_i;
    logic rst_ni;
    logic flush_i;
    logic [DISP_WIDTH-1:0] disp_valid_i;
    alu_op_e [DISP_WIDTH-1:0] disp_op_i;
    rob_idx_t [DISP_WIDTH-1:0] disp_rob_idx_i;
    logic [DISP_WIDTH-1:0] disp_rs1_ready_i;
    rob_idx_t [DISP_WIDTH-1:0] disp_rs1_tag_i;
    xlen_t [DISP_WIDTH-1:0] disp_rs1_data_i;
    logic [DISP_WIDTH-1:0] disp_rs2_ready_i;
    rob_idx_t [DISP_WIDTH-1:0] disp_rs2_tag_i;
    xlen_t [DISP_WIDTH-1:0] disp_rs2_data_i;
    logic full_o;
    logic [WB_WIDTH-1:0] wb_valid_o;
    rob_idx_t [WB_WIDTH-1:0] wb_tag_o;
    xlen_t [WB_WIDTH-1:0] wb_data_o;

    // reference model, indexed by tag
    xlen_t model [TAGS];
    bit pending [TAGS];
    bit seen [TAGS];
    // expected arrival cycle, -1 when latency is free
    int exp_cyc [TAGS];

    int cyc = 0;
    int errors = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    int issued_cnt = 0;
    int returned_cnt = 0;
    // entries held since the full test started
    int held = 0;
    bit full_chk = 1'b0;
    bit idle_chk = 1'b0;
    bit after_flush = 1'b0;

    ooo_issue_top UUT (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .disp_valid_i     (disp_valid_i),
        .disp_op_i        (disp_op_i),
        .disp_rob_idx_i   (disp_rob_idx_i),
        .disp_rs1_ready_i (disp_rs1_ready_i),
        .disp_rs1_tag_i   (disp_rs1_tag_i),
        .disp_rs1_data_i  (disp_rs1_data_i),
        .disp_rs2_ready_i (disp_rs2_ready_i),
        .disp_rs2_tag_i   (disp_rs2_tag_i),
        .disp_rs2_data_i  (disp_rs2_data_i),
        .full_o           (full_o),
        .wb_valid_o       (wb_valid_o),
        .wb_tag_o         (wb_tag_o),
        .wb_data_o        (wb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ==================================================================
    // monitors and assertions
    // ==================================================================

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        after_flush <= flush_i;
        if (flush_i || !full_chk) begin
            held <= 0;
        end else begin
            held <= held + $countones(disp_valid_i);
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk_i) begin : wb_monitor
        int got;
        got = 0;
        if (rst_ni) begin
            for (int l = 0; l < WB_WIDTH; l++) begin
                if (wb_valid_o[l] && pending[wb_tag_o[l]] && !seen[wb_tag_o[l]]) begin
                    seen[wb_tag_o[l]] <= 1'b1;
                    got++;
                end
            end
        end
        returned_cnt <= returned_cnt + got;
    end

    for (genvar l = 0; l < WB_WIDTH; l++) begin : g_wb_check
        a_known_tag: assert property (@(negedge clk_i) disable iff (!rst_ni)
            wb_valid_o[l] |-> (pending[wb_tag_o[l]] && !seen[wb_tag_o[l]]))
            else begin
                errors++;
                $display("tag %0d on writeback lane %0d was not expected or came back twice",
                         wb_tag_o[l], l);
            end
        a_wb_value: assert property (@(negedge clk_i) disable iff (!rst_ni)
            (wb_valid_o[l] && pending[wb_tag_o[l]]) |-> (wb_data_o[l] == model[wb_tag_o[l]]))
            else begin
                errors++;
                $display("Mismatch at %0t: wb_data_o[%0d] expected %h, got %h",
                         $time, l, model[wb_tag_o[l]], wb_data_o[l]);
            end
        a_wb_cycle: assert property (@(negedge clk_i) disable iff (!rst_ni)
            (wb_valid_o[l] && pending[wb_tag_o[l]] && exp_cyc[wb_tag_o[l]] >= 0)
                |-> (cyc == exp_cyc[wb_tag_o[l]]))
            else begin
                errors++;
                $display("tag %0d written back in cycle %0d instead of cycle %0d",
                         wb_tag_o[l], cyc, exp_cyc[wb_tag_o[l]]);
            end
    end

    a_full_flag: assert property (@(negedge clk_i) disable iff (!rst_ni)
        full_chk |-> (full_o == ((IQ_DEPTH - held) < DISP_WIDTH)))
        else begin
            errors++;
            $display("Mismatch at %0t: full_o expected %0b, got %0b",
                     $time, (IQ_DEPTH - held) < DISP_WIDTH, full_o);
        end

    a_quiet_after_flush: assert property (@(negedge clk_i) disable iff (!rst_ni)
        after_flush |-> (wb_valid_o == '0))
        else begin
            errors++;
            $display("a writeback was valid right after flush_i");
        end

    a_idle_after_reset: assert property (@(negedge clk_i) disable iff (!rst_ni)
        idle_chk |-> (!full_o && wb_valid_o == '0))
        else begin
            errors++;
            $display("full_o or wb_valid_o was high straight out of reset");
        end

    // ==================================================================
    // model and drive helpers
    // ==================================================================

    function automatic xlen_t alu_model(input alu_op_e op, input xlen_t a, input xlen_t b);
        case (op)
            ADD: return a + b;
            SUB: return a - b;
            AND: return a & b;
            OR:  return a | b;
            XOR: return a ^ b;
            SLL: return a << b[4:0];
            SRL: return a >> b[4:0];
            SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    // wait for the edge, then drop last cycle's strobes
    task automatic next_cycle();
        @(posedge clk_i);
        #(DRIVE_DELAY);
        disp_valid_i = '0;
    endtask

    // pN set means source N waits on tag tN, else it carries dN
    task automatic put_lane(input int l, input alu_op_e op, input rob_idx_t tag,
                            input bit p1, input rob_idx_t t1, input xlen_t d1,
                            input bit p2, input rob_idx_t t2, input xlen_t d2,
                            input int exp_at);
        xlen_t a;
        xlen_t b;
        a = p1 ? model[t1] : d1;
        b = p2 ? model[t2] : d2;
        disp_valid_i[l] = 1'b1;
        disp_op_i[l] = op;
        disp_rob_idx_i[l] = tag;
        disp_rs1_ready_i[l] = !p1;
        disp_rs1_tag_i[l] = t1;
        // junk data on a pending source must not leak through
        disp_rs1_data_i[l] = p1 ? $urandom : d1;
        disp_rs2_ready_i[l] = !p2;
        disp_rs2_tag_i[l] = t2;
        disp_rs2_data_i[l] = p2 ? $urandom : d2;
        model[tag] = alu_model(op, a, b);
        exp_cyc[tag] = exp_at;
        pending[tag] = 1'b1;
        issued_cnt++;
    endtask

    // earlier result of the random test, or fresh data
    task automatic pick_src(input int used, output bit p, output rob_idx_t t, output xlen_t d);
        if (used > 0 && $urandom_range(1, 0) == 1) begin
            t = rob_idx_t'(RAND_BASE + $urandom_range(used - 1, 0));
            // already broadcast means the value comes as plain data
            p = !seen[t];
            d = model[t];
        end else begin
            p = 1'b0;
            t = NEVER_TAG;
            d = $urandom;
        end
    endtask

    task automatic wait_drained();
        while (returned_cnt != issued_cnt) begin
            @(posedge clk_i);
        end
        repeat (3) next_cycle();
    endtask

    task automatic finish_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            pass_cnt++;
            $display("test %0d %s: passed", num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
        end
    endtask

    // ==================================================================
    // tests
    // ==================================================================

    task automatic test_independent();
        int e;
        e = errors;
        idle_chk = 1'b1;
        repeat (3) next_cycle();
        idle_chk = 1'b0;
        // every operation once, one per cycle, no contention
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            put_lane(i % 2, alu_op_e'(3'(i)), rob_idx_t'(i), 1'b0, NEVER_TAG, $urandom,
                     1'b0, NEVER_TAG, $urandom, cyc + 3);
        end
        next_cycle();
        wait_drained();
        finish_test(1, "reset and independent ops", e);
    endtask

    task automatic test_chain();
        int e;
        int prev_at;
        e = errors;
        next_cycle();
        put_lane(0, ADD, rob_idx_t'(CHAIN_BASE), 1'b0, NEVER_TAG, $urandom,
                 1'b0, NEVER_TAG, $urandom, cyc + 3);
        prev_at = cyc + 3;
        for (int i = 1; i < 5; i++) begin
            next_cycle();
            put_lane(0, alu_op_e'(3'($urandom_range(7, 0))), rob_idx_t'(CHAIN_BASE + i),
                     1'b1, rob_idx_t'(CHAIN_BASE + i - 1), '0,
                     1'b0, NEVER_TAG, $urandom, prev_at + 2);
            prev_at = prev_at + 2;
        end
        next_cycle();
        wait_drained();
        finish_test(2, "dependency wakeup", e);
    endtask

    task automatic test_forward();
        int e;
        int d;
        e = errors;
        next_cycle();
        d = cyc;
        put_lane(0, SUB, rob_idx_t'(FWD_BASE), 1'b0, NEVER_TAG, $urandom,
                 1'b0, NEVER_TAG, $urandom, d + 3);
        repeat (3) next_cycle();
        // both consumers strobe in the producer's writeback cycle
        // forwarded at dispatch, so they take the plain three cycles
        put_lane(0, XOR, rob_idx_t'(FWD_BASE + 1), 1'b1, rob_idx_t'(FWD_BASE), '0,
                 1'b0, NEVER_TAG, $urandom, d + 6);
        put_lane(1, SLL, rob_idx_t'(FWD_BASE + 2), 1'b0, NEVER_TAG, $urandom,
                 1'b1, rob_idx_t'(FWD_BASE), '0, d + 6);
        next_cycle();
        wait_drained();
        finish_test(3, "same-cycle forwarding", e);
    endtask

    task automatic test_full_flush();
        int e;
        int n;
        e = errors;
        n = 0;
        next_cycle();
        full_chk = 1'b1;
        // fill with micro-ops that can never wake before the flush
        while (!full_o && n < IQ_DEPTH) begin
            for (int l = 0; l < DISP_WIDTH; l++) begin
                put_lane(l, OR, rob_idx_t'(FULL_BASE + n), 1'b1, NEVER_TAG, '0,
                         1'b0, NEVER_TAG, $urandom, -1);
                n++;
            end
            next_cycle();
        end
        repeat (2) next_cycle();
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        // any of these tags coming back now is an error
        for (int i = 0; i < n; i++) begin
            pending[FULL_BASE + i] = 1'b0;
        end
        issued_cnt = issued_cnt - n;
        repeat (3) next_cycle();
        // broadcast of the awaited tag wakes whatever the flush left behind
        put_lane(0, AND, NEVER_TAG, 1'b0, NEVER_TAG, $urandom,
                 1'b0, NEVER_TAG, $urandom, cyc + 3);
        repeat (3) next_cycle();
        // sits in its issue cycle when the second flush hits
        put_lane(0, ADD, DROP_TAG, 1'b0, NEVER_TAG, $urandom,
                 1'b0, NEVER_TAG, $urandom, -1);
        repeat (2) next_cycle();
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        pending[DROP_TAG] = 1'b0;
        issued_cnt--;
        repeat (5) next_cycle();
        full_chk = 1'b0;
        finish_test(4, "full and flush", e);
    endtask

    task automatic test_random();
        int e;
        int used;
        bit p1;
        bit p2;
        rob_idx_t t1;
        rob_idx_t t2;
        xlen_t d1;
        xlen_t d2;
        e = errors;
        used = 0;
        while (used < RAND_OPS) begin
            next_cycle();
            if (!full_o) begin
                for (int l = 0; l < DISP_WIDTH; l++) begin
                    if (used < RAND_OPS && $urandom_range(3, 0) != 0) begin
                        pick_src(used, p1, t1, d1);
                        pick_src(used, p2, t2, d2);
                        put_lane(l, alu_op_e'(3'($urandom_range(7, 0))),
                                 rob_idx_t'(RAND_BASE + used), p1, t1, d1, p2, t2, d2, -1);
                        used++;
                    end
                end
            end
        end
        next_cycle();
        wait_drained();
        finish_test(5, "random mix", e);
    endtask

    // ==================================================================
    // main sequence and watchdog
    // ==================================================================

    initial begin
        void'($urandom(32'hd11e_ecb7));
        rst_ni = 1'b0;
        flush_i = 1'b0;
        disp_valid_i = '0;
        disp_rob_idx_i = '0;
        disp_rs1_ready_i = '0;
        disp_rs1_tag_i = '0;
        disp_rs1_data_i = '0;
        disp_rs2_ready_i = '0;
        disp_rs2_tag_i = '0;
        disp_rs2_data_i = '0;
        for (int l = 0; l < DISP_WIDTH; l++) begin
            disp_op_i[l] = ADD;
        end
        for (int t = 0; t < TAGS; t++) begin
            exp_cyc[t] = -1;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_ni = 1'b1;
        test_independent();
        test_chain();
        test_forward();
        test_full_flush();
        test_random();
        $display("tests passed %0d, failed %0d, check failures %0d",
                 pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog expired after %0d cycles with results still missing",
                 WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
